//--- rtl/rrag_pkg.sv
package rrag_pkg;

    // ==========================================================================
    // architectural widths
    // ==========================================================================
    localparam int WORD_BITS  = 32;
    localparam int SEL_BITS   = 16;
    localparam int RADDR_BITS = 3;
    localparam int TAG_BITS   = 4;
    localparam int NUM_REGS   = 8;

    // 4 KB pages
    localparam int PAGE_BITS  = 12;

    // selector to linear base
    localparam int SEG_SHIFT  = 16;

    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [SEL_BITS-1:0]   sel_t;
    typedef logic [RADDR_BITS-1:0] raddr_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [1:0]            opsize_t;
    typedef logic [NUM_REGS-1:0]   rmask_t;

    // ==========================================================================
    // operand size codes
    // ==========================================================================
    localparam opsize_t OPSIZE_1B = 2'd0;
    localparam opsize_t OPSIZE_2B = 2'd1;
    localparam opsize_t OPSIZE_4B = 2'd2;
    localparam opsize_t OPSIZE_8B = 2'd3;

endpackage

//--- rtl/rrag_ifs.sv
`timescale 1ns/1ps

// ==========================================================================
// general register read bundle
// ==========================================================================
interface gpr_read_if import rrag_pkg::*; ();

    word_t data1;
    word_t data2;
    word_t data3;
    word_t data4;
    // port 1 is never used for an address, so it carries no pending bit
    logic  pend2;
    logic  pend3;
    logic  pend4;

    modport src (output data1, data2, data3, data4, pend2, pend3, pend4);
    modport dst (input  data1, data2, data3, data4, pend2, pend3, pend4);

endinterface

// ==========================================================================
// segment selector read bundle
// ==========================================================================
interface seg_read_if import rrag_pkg::*; ();

    sel_t sel1;
    sel_t sel2;
    logic pend1;
    logic pend2;

    modport src (output sel1, sel2, pend1, pend2);
    modport dst (input  sel1, sel2, pend1, pend2);

endinterface

// ==========================================================================
// issue strobe with tag and destination masks
// ==========================================================================
interface issue_if import rrag_pkg::*; ();

    logic   issue;
    tag_t   tag;
    rmask_t reg_dest;
    rmask_t seg_dest;

    modport drv  (output issue, tag, reg_dest, seg_dest);
    modport mark (input  issue, tag, reg_dest, seg_dest);

endinterface

//--- rtl/gpr_file.sv
`timescale 1ns/1ps

module gpr_file import rrag_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   ptc_clear,

    // read addresses
    input  raddr_t rd_addr1,
    input  raddr_t rd_addr2,
    input  raddr_t rd_addr3,
    input  raddr_t rd_addr4,

    // writeback
    input  logic   wb_reg_ld,
    input  raddr_t wb_reg_addr,
    input  word_t  wb_data,
    input  tag_t   wb_tag,

    gpr_read_if.src rd,
    issue_if.mark   iss
);

    word_t               regs [NUM_REGS];
    tag_t                ptag [NUM_REGS];
    logic [NUM_REGS-1:0] pend;

    // ==========================================================================
    // register data
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_reg_ld) begin
            regs[wb_reg_addr] <= wb_data;
        end
    end

    // ==========================================================================
    // pending marks and writer tags
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                ptag[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (iss.issue && iss.reg_dest[i]) begin
                    // a new writer wins over any clear in the same cycle
                    pend[i] <= 1'b1;
                    ptag[i] <= iss.tag;
                end else if (ptc_clear) begin
                    pend[i] <= 1'b0;
                end else if (wb_reg_ld && (wb_reg_addr == raddr_t'(i)) &&
                             pend[i] && (ptag[i] == wb_tag)) begin
                    // only the latest writer releases the register
                    pend[i] <= 1'b0;
                end
            end
        end
    end

    // ==========================================================================
    // read ports
    // ==========================================================================
    assign rd.data1 = regs[rd_addr1];
    assign rd.data2 = regs[rd_addr2];
    assign rd.data3 = regs[rd_addr3];
    assign rd.data4 = regs[rd_addr4];

    assign rd.pend2 = pend[rd_addr2];
    assign rd.pend3 = pend[rd_addr3];
    assign rd.pend4 = pend[rd_addr4];

    a_wb_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_reg_ld |-> !$isunknown(wb_reg_addr)
    ) else $error("gpr writeback with unknown address");

endmodule

//--- rtl/seg_file.sv
`timescale 1ns/1ps

module seg_file import rrag_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   ptc_clear,

    input  raddr_t rd_addr1,
    input  raddr_t rd_addr2,

    // writeback
    input  logic   wb_seg_ld,
    input  raddr_t wb_seg_addr,
    input  sel_t   wb_sel,
    input  tag_t   wb_tag,

    seg_read_if.src rd,
    issue_if.mark   iss
);

    sel_t                sels [NUM_REGS];
    tag_t                ptag [NUM_REGS];
    logic [NUM_REGS-1:0] pend;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                sels[i] <= '0;
            end
        end else if (wb_seg_ld) begin
            sels[wb_seg_addr] <= wb_sel;
        end
    end

    // ==========================================================================
    // pending marks, same priority as the general registers
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                ptag[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (iss.issue && iss.seg_dest[i]) begin
                    pend[i] <= 1'b1;
                    ptag[i] <= iss.tag;
                end else if (ptc_clear) begin
                    pend[i] <= 1'b0;
                end else if (wb_seg_ld && (wb_seg_addr == raddr_t'(i)) &&
                             pend[i] && (ptag[i] == wb_tag)) begin
                    pend[i] <= 1'b0;
                end
            end
        end
    end

    assign rd.sel1  = sels[rd_addr1];
    assign rd.sel2  = sels[rd_addr2];
    assign rd.pend1 = pend[rd_addr1];
    assign rd.pend2 = pend[rd_addr2];

endmodule

//--- rtl/addr_gen.sv
`timescale 1ns/1ps

module addr_gen import rrag_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    valid_in,
    input  logic    latch_empty,
    input  logic    fwd_stall,

    // address operands
    input  word_t   disp,
    input  logic [1:0] scale,
    input  logic    use_base,
    input  logic    use_index,
    input  logic    seg_bypass,
    input  opsize_t opsize,
    input  logic [1:0] mem1_rw,
    input  logic [1:0] mem2_rw,

    // registers this instruction will write
    input  rmask_t  dest_regs,
    input  rmask_t  dest_segs,

    gpr_read_if.dst gr,
    seg_read_if.dst sr,
    issue_if.drv    iss,

    output logic    valid_out,
    output logic    stall,
    output word_t   mem_addr1,
    output word_t   mem_addr2,
    output word_t   mem_addr1_end,
    output logic    mem1_cross,
    output tag_t    inst_tag
);

    word_t seg_base1;
    word_t seg_base2;
    word_t base_term;
    word_t index_term;
    word_t size_m1;
    logic  mem1_used;
    logic  mem2_used;
    logic  mem1_pend;
    logic  mem2_pend;
    tag_t  tag_q;

    // ==========================================================================
    // address arithmetic
    // ==========================================================================
    assign seg_base1  = seg_bypass ? '0 : (word_t'(sr.sel1) << SEG_SHIFT);
    assign seg_base2  = word_t'(sr.sel2) << SEG_SHIFT;
    assign base_term  = use_base ? gr.data2 : '0;
    // scaled index, x1 x2 x4 x8
    assign index_term = use_index ? (gr.data3 << scale) : '0;

    assign mem_addr1 = seg_base1 + disp + base_term + index_term;
    assign mem_addr2 = seg_base2 + gr.data4;

    // last byte offset of the access
    always_comb begin
        case (opsize)
            OPSIZE_1B: size_m1 = word_t'(0);
            OPSIZE_2B: size_m1 = word_t'(1);
            OPSIZE_4B: size_m1 = word_t'(3);
            OPSIZE_8B: size_m1 = word_t'(7);
            default:   size_m1 = word_t'(0);
        endcase
    end

    assign mem_addr1_end = mem_addr1 + size_m1;
    assign mem1_cross    = mem_addr1[WORD_BITS-1:PAGE_BITS] !=
                           mem_addr1_end[WORD_BITS-1:PAGE_BITS];

    // ==========================================================================
    // stall and valid
    // ==========================================================================
    assign mem1_used = |mem1_rw;
    assign mem2_used = |mem2_rw;

    assign mem1_pend = (use_base && gr.pend2) || (use_index && gr.pend3) || sr.pend1;
    assign mem2_pend = gr.pend4 || sr.pend2;

    assign stall = valid_in && (fwd_stall ||
                                (mem1_used && mem1_pend) ||
                                (mem2_used && mem2_pend));

    assign valid_out = valid_in && !latch_empty && !stall;

    // ==========================================================================
    // issue and tag counter
    // ==========================================================================
    assign iss.issue    = valid_out;
    assign iss.tag      = tag_q;
    assign iss.reg_dest = dest_regs;
    assign iss.seg_dest = dest_segs;
    assign inst_tag     = tag_q;

    // wraps at 16 by width
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else if (valid_out) begin
            tag_q <= tag_q + tag_t'(1);
        end
    end

    a_no_issue_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(valid_out && stall)
    ) else $error("valid_out and stall high together");

    a_tag_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (tag_q == tag_t'($past(tag_q) + tag_t'($past(iss.issue))))
    ) else $error("tag counter did not follow issue");

endmodule

//--- rtl/rrag.sv
`timescale 1ns/1ps

module rrag import rrag_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ptc_clear,

    input  logic       valid_in,
    input  logic       latch_empty,
    input  logic       fwd_stall,

    // register and segment read addresses
    input  raddr_t     reg_addr1,
    input  raddr_t     reg_addr2,
    input  raddr_t     reg_addr3,
    input  raddr_t     reg_addr4,
    input  raddr_t     seg_addr1,
    input  raddr_t     seg_addr2,

    // address operands
    input  word_t      disp,
    input  logic [1:0] scale,
    input  logic       use_base,
    input  logic       use_index,
    input  logic       seg_bypass,
    input  opsize_t    opsize,
    input  logic [1:0] mem1_rw,
    input  logic [1:0] mem2_rw,
    input  rmask_t     dest_regs,
    input  rmask_t     dest_segs,

    // writeback
    input  logic       wb_reg_ld,
    input  raddr_t     wb_reg_addr,
    input  word_t      wb_data,
    input  logic       wb_seg_ld,
    input  raddr_t     wb_seg_addr,
    input  sel_t       wb_sel,
    input  tag_t       wb_tag,

    output logic       valid_out,
    output logic       stall,
    output word_t      reg1,
    output word_t      reg2,
    output word_t      reg3,
    output word_t      reg4,
    output sel_t       seg1,
    output sel_t       seg2,
    output word_t      mem_addr1,
    output word_t      mem_addr2,
    output word_t      mem_addr1_end,
    output logic       mem1_cross,
    output tag_t       inst_tag
);

    gpr_read_if gr_if ();
    seg_read_if sr_if ();
    issue_if    iss_if ();

    gpr_file u_gpr (
        .clk         (clk),
        .rst_n       (rst_n),
        .ptc_clear   (ptc_clear),
        .rd_addr1    (reg_addr1),
        .rd_addr2    (reg_addr2),
        .rd_addr3    (reg_addr3),
        .rd_addr4    (reg_addr4),
        .wb_reg_ld   (wb_reg_ld),
        .wb_reg_addr (wb_reg_addr),
        .wb_data     (wb_data),
        .wb_tag      (wb_tag),
        .rd          (gr_if),
        .iss         (iss_if)
    );

    seg_file u_seg (
        .clk         (clk),
        .rst_n       (rst_n),
        .ptc_clear   (ptc_clear),
        .rd_addr1    (seg_addr1),
        .rd_addr2    (seg_addr2),
        .wb_seg_ld   (wb_seg_ld),
        .wb_seg_addr (wb_seg_addr),
        .wb_sel      (wb_sel),
        .wb_tag      (wb_tag),
        .rd          (sr_if),
        .iss         (iss_if)
    );

    addr_gen u_agen (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .latch_empty   (latch_empty),
        .fwd_stall     (fwd_stall),
        .disp          (disp),
        .scale         (scale),
        .use_base      (use_base),
        .use_index     (use_index),
        .seg_bypass    (seg_bypass),
        .opsize        (opsize),
        .mem1_rw       (mem1_rw),
        .mem2_rw       (mem2_rw),
        .dest_regs     (dest_regs),
        .dest_segs     (dest_segs),
        .gr            (gr_if),
        .sr            (sr_if),
        .iss           (iss_if),
        .valid_out     (valid_out),
        .stall         (stall),
        .mem_addr1     (mem_addr1),
        .mem_addr2     (mem_addr2),
        .mem_addr1_end (mem_addr1_end),
        .mem1_cross    (mem1_cross),
        .inst_tag      (inst_tag)
    );

    // operand values to the next stage
    assign reg1 = gr_if.data1;
    assign reg2 = gr_if.data2;
    assign reg3 = gr_if.data3;
    assign reg4 = gr_if.data4;
    assign seg1 = sr_if.sel1;
    assign seg2 = sr_if.sel2;

endmodule

//--- sim/rrag_tb.sv
`timescale 1ns/1ps

module rrag_tb import rrag_pkg::*; ();

    localparam int WAIT_LIMIT = 20;

    logic       clk;
    logic       rst_n;
    logic       ptc_clear, valid_in, latch_empty, fwd_stall;
    raddr_t     reg_addr1, reg_addr2, reg_addr3, reg_addr4, seg_addr1, seg_addr2;
    word_t      disp;
    logic [1:0] scale, mem1_rw, mem2_rw;
    logic       use_base, use_index, seg_bypass;
    opsize_t    opsize;
    rmask_t     dest_regs, dest_segs;
    logic       wb_reg_ld, wb_seg_ld;
    raddr_t     wb_reg_addr, wb_seg_addr;
    word_t      wb_data;
    sel_t       wb_sel;
    tag_t       wb_tag;

    logic       valid_out, stall, mem1_cross;
    word_t      reg1, reg2, reg3, reg4, mem_addr1, mem_addr2, mem_addr1_end;
    sel_t       seg1, seg2;
    tag_t       inst_tag;

    // shadow model of both files and the tag counter
    word_t               m_regs [NUM_REGS];
    sel_t                m_sels [NUM_REGS];
    tag_t                m_rtag [NUM_REGS];
    tag_t                m_stag [NUM_REGS];
    logic [NUM_REGS-1:0] m_rpend, m_spend;
    tag_t                m_tag;

    word_t exp_reg1, exp_reg2, exp_reg3, exp_reg4, exp_mem1, exp_mem2, exp_end;
    sel_t  exp_seg1, exp_seg2;
    logic  exp_cross, exp_stall, exp_valid;

    int          errors;
    int          timeouts;
    string       test_name;
    logic [31:0] rng_state;

    rrag UUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // ========================================================================
    // expected outputs from the model state and the current inputs
    // ========================================================================
    always_comb begin
        exp_reg1 = m_regs[reg_addr1];
        exp_reg2 = m_regs[reg_addr2];
        exp_reg3 = m_regs[reg_addr3];
        exp_reg4 = m_regs[reg_addr4];
        exp_seg1 = m_sels[seg_addr1];
        exp_seg2 = m_sels[seg_addr2];
        exp_mem1 = disp;
        if (!seg_bypass) exp_mem1 += {m_sels[seg_addr1], 16'h0000};
        if (use_base) exp_mem1 += m_regs[reg_addr2];
        if (use_index) exp_mem1 += m_regs[reg_addr3] * (32'd1 << scale);
        exp_mem2  = {m_sels[seg_addr2], 16'h0000} + m_regs[reg_addr4];
        exp_end   = exp_mem1 + (32'd1 << opsize) - 32'd1;
        exp_cross = (exp_mem1 >> PAGE_BITS) != (exp_end >> PAGE_BITS);
        exp_stall = valid_in && (fwd_stall ||
            ((mem1_rw != 2'b00) && ((use_base && m_rpend[reg_addr2]) ||
                (use_index && m_rpend[reg_addr3]) || m_spend[seg_addr1])) ||
            ((mem2_rw != 2'b00) && (m_rpend[reg_addr4] || m_spend[seg_addr2])));
        exp_valid = valid_in && !latch_empty && !exp_stall;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                m_regs[i] <= '0;
                m_sels[i] <= '0;
                m_rtag[i] <= '0;
                m_stag[i] <= '0;
            end
            m_rpend <= '0;
            m_spend <= '0;
            m_tag   <= '0;
        end else begin
            if (wb_reg_ld) m_regs[wb_reg_addr] <= wb_data;
            if (wb_seg_ld) m_sels[wb_seg_addr] <= wb_sel;
            for (int i = 0; i < NUM_REGS; i++) begin
                if (exp_valid && dest_regs[i]) begin
                    m_rpend[i] <= 1'b1;
                    m_rtag[i]  <= m_tag;
                end else if (ptc_clear) begin
                    m_rpend[i] <= 1'b0;
                end else if (wb_reg_ld && wb_reg_addr == i && m_rtag[i] == wb_tag) begin
                    m_rpend[i] <= 1'b0;
                end
                if (exp_valid && dest_segs[i]) begin
                    m_spend[i] <= 1'b1;
                    m_stag[i]  <= m_tag;
                end else if (ptc_clear) begin
                    m_spend[i] <= 1'b0;
                end else if (wb_seg_ld && wb_seg_addr == i && m_stag[i] == wb_tag) begin
                    m_spend[i] <= 1'b0;
                end
            end
            if (exp_valid) m_tag <= m_tag + tag_t'(1);
        end
    end

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    // ========================================================================
    // checks on every rising edge
    // ========================================================================
    a_reg1: assert property (@(posedge clk) disable iff (!rst_n) reg1 == exp_reg1)
        else report_mismatch("reg1", $sampled(exp_reg1), $sampled(reg1));
    a_reg2: assert property (@(posedge clk) disable iff (!rst_n) reg2 == exp_reg2)
        else report_mismatch("reg2", $sampled(exp_reg2), $sampled(reg2));
    a_reg3: assert property (@(posedge clk) disable iff (!rst_n) reg3 == exp_reg3)
        else report_mismatch("reg3", $sampled(exp_reg3), $sampled(reg3));
    a_reg4: assert property (@(posedge clk) disable iff (!rst_n) reg4 == exp_reg4)
        else report_mismatch("reg4", $sampled(exp_reg4), $sampled(reg4));
    a_seg1: assert property (@(posedge clk) disable iff (!rst_n) seg1 == exp_seg1)
        else report_mismatch("seg1", $sampled(exp_seg1), $sampled(seg1));
    a_seg2: assert property (@(posedge clk) disable iff (!rst_n) seg2 == exp_seg2)
        else report_mismatch("seg2", $sampled(exp_seg2), $sampled(seg2));
    a_mem1: assert property (@(posedge clk) disable iff (!rst_n) mem_addr1 == exp_mem1)
        else report_mismatch("mem_addr1", $sampled(exp_mem1), $sampled(mem_addr1));
    a_mem2: assert property (@(posedge clk) disable iff (!rst_n) mem_addr2 == exp_mem2)
        else report_mismatch("mem_addr2", $sampled(exp_mem2), $sampled(mem_addr2));
    a_end: assert property (@(posedge clk) disable iff (!rst_n) mem_addr1_end == exp_end)
        else report_mismatch("mem_addr1_end", $sampled(exp_end), $sampled(mem_addr1_end));
    a_cross: assert property (@(posedge clk) disable iff (!rst_n) mem1_cross == exp_cross)
        else report_mismatch("mem1_cross", $sampled(exp_cross), $sampled(mem1_cross));
    a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == exp_stall)
        else report_mismatch("stall", $sampled(exp_stall), $sampled(stall));
    a_valid: assert property (@(posedge clk) disable iff (!rst_n) valid_out == exp_valid)
        else report_mismatch("valid_out", $sampled(exp_valid), $sampled(valid_out));
    a_tag: assert property (@(posedge clk) disable iff (!rst_n) inst_tag == m_tag)
        else report_mismatch("inst_tag", $sampled(m_tag), $sampled(inst_tag));

    task automatic drive_idle();
        {ptc_clear, valid_in, latch_empty, fwd_stall} = '0;
        {reg_addr1, reg_addr2, reg_addr3, reg_addr4, seg_addr1, seg_addr2} = '0;
        {disp, scale, use_base, use_index, seg_bypass, opsize} = '0;
        {mem1_rw, mem2_rw, dest_regs, dest_segs} = '0;
        {wb_reg_ld, wb_reg_addr, wb_data, wb_seg_ld, wb_seg_addr, wb_sel, wb_tag} = '0;
    endtask

    // waits end on a rising edge, where the outputs are still settled
    task automatic await_stall(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (stall !== 1'b1 && n < WAIT_LIMIT);
        if (stall !== 1'b1) begin
            timeouts++;
            $display("timeout in %s: stall never rose (%s)", test_name, what);
        end
    endtask

    task automatic await_issue(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (valid_out !== 1'b1 && n < WAIT_LIMIT);
        if (valid_out !== 1'b1) begin
            timeouts++;
            $display("timeout in %s: valid_out never rose (%s)", test_name, what);
        end
    endtask

    initial begin
        logic [31:0] r;
        tag_t        tag_a;
        clk       = 1'b0;
        rst_n     = 1'b0;
        errors    = 0;
        timeouts  = 0;
        rng_state = 32'd59;
        test_name = "reset";
        drive_idle();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // ====================================================================
        // readback, then address arithmetic and page crossing
        // ====================================================================
        test_name = "readback";
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            {reg_addr1, reg_addr2, reg_addr3, reg_addr4, seg_addr1, seg_addr2} = r[17:0];
            {wb_reg_ld, wb_reg_addr, wb_seg_ld, wb_seg_addr, wb_tag} = r[31:20];
            wb_reg_ld = wb_reg_ld | (i < 16);
            wb_data   = next_rand();
            wb_sel    = sel_t'(next_rand());
            @(negedge clk);
        end
        drive_idle();
        test_name = "addr_arith";
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            {reg_addr1, reg_addr2, reg_addr3, reg_addr4, seg_addr1, seg_addr2} = r[17:0];
            {scale, use_base, use_index, seg_bypass, opsize, mem1_rw, mem2_rw} = r[28:18];
            disp     = next_rand();
            valid_in = 1'b1;
            @(negedge clk);
        end
        test_name = "end_cross";
        {use_base, use_index, seg_bypass} = 3'b001;
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 10; k++) begin
                r      = next_rand();
                opsize = opsize_t'(s);
                disp   = {r[31:12], 12'hff8 + 12'(k)};
                @(negedge clk);
            end
        end

        // ====================================================================
        // pending marks, tags and release
        // ====================================================================
        test_name = "pending";
        drive_idle();
        valid_in  = 1'b1;
        dest_regs = 8'h08;
        tag_a     = m_tag;
        @(negedge clk);
        dest_regs = '0;
        reg_addr2 = 3'd3;
        use_base  = 1'b1;
        mem1_rw   = 2'b10;
        await_stall("base register 3 pending");
        @(negedge clk);
        {wb_reg_ld, wb_reg_addr, wb_data, wb_tag} = {1'b1, 3'd3, next_rand(), tag_a + 4'd1};
        @(negedge clk);
        wb_reg_ld = 1'b0;
        repeat (2) @(negedge clk);
        {wb_reg_ld, wb_tag} = {1'b1, tag_a};
        @(negedge clk);
        wb_reg_ld = 1'b0;
        await_issue("matching tag releases register 3");
        @(negedge clk);
        drive_idle();
        valid_in  = 1'b1;
        dest_segs = 8'h20;
        dest_regs = 8'h40;
        tag_a     = m_tag;
        @(negedge clk);
        {dest_segs, dest_regs} = '0;
        {seg_addr2, mem2_rw} = {3'd5, 2'b01};
        await_stall("segment 5 pending");
        @(negedge clk);
        {wb_seg_ld, wb_seg_addr, wb_sel, wb_tag} = {1'b1, 3'd5, 16'h1234, tag_a};
        @(negedge clk);
        {wb_seg_ld, mem2_rw} = '0;
        {reg_addr3, use_index, mem1_rw} = {3'd6, 1'b1, 2'b11};
        await_stall("index register 6 pending");
        @(negedge clk);
        {wb_reg_ld, wb_reg_addr, wb_data, wb_tag} = {1'b1, 3'd6, next_rand(), tag_a};
        @(negedge clk);
        wb_reg_ld = 1'b0;
        await_issue("matching tag releases register 6");

        // ====================================================================
        // global clear, forward stall and empty latch
        // ====================================================================
        test_name = "clear_gate";
        @(negedge clk);
        drive_idle();
        {valid_in, dest_regs, dest_segs} = {1'b1, 8'hff, 8'hff};
        @(negedge clk);
        {dest_regs, dest_segs} = '0;
        {reg_addr2, use_base, mem1_rw} = {3'd2, 1'b1, 2'b01};
        await_stall("all registers pending");
        @(negedge clk);
        ptc_clear = 1'b1;
        @(negedge clk);
        ptc_clear = 1'b0;
        await_issue("ptc_clear releases every mark");
        @(negedge clk);
        {use_base, mem1_rw, dest_regs, ptc_clear} = {1'b0, 2'b00, 8'h02, 1'b1};
        @(negedge clk);
        {dest_regs, ptc_clear} = '0;
        {reg_addr2, use_base, mem1_rw} = {3'd1, 1'b1, 2'b01};
        await_stall("issue mark kept over same-cycle clear");
        @(negedge clk);
        ptc_clear = 1'b1;
        @(negedge clk);
        ptc_clear = 1'b0;
        await_issue("second clear releases register 1");
        @(negedge clk);
        drive_idle();
        {valid_in, fwd_stall} = 2'b11;
        await_stall("fwd_stall");
        @(negedge clk);
        {fwd_stall, latch_empty} = 2'b01;
        repeat (3) @(negedge clk);
        latch_empty = 1'b0;
        await_issue("latch refilled");
        @(negedge clk);
        drive_idle();
        repeat (2) @(negedge clk);

        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
rtl/rrag_pkg.sv
rtl/rrag_ifs.sv
rtl/gpr_file.sv
rtl/seg_file.sv
rtl/addr_gen.sv
rtl/rrag.sv
sim/rrag_tb.sv
